// ==== dv/fifo_stimulus.txt ====
# op arg, arg in hex: W writes arg, R reads and expects arg on rd_data, Q idles arg rd_clk cycles
# F checks the settled flags for a fill count of arg; a refused read expects the previous word
Q 0c
F 00
R 00
W 01
Q 0c
F 01
R 01
R 01
W 10
W 11
W 12
W 13
W 14
W 15
W 16
W 17
W 18
W 19
W 1a
W 1b
W 1c
W 1d
W 1e
W 1f
W ee
Q 0c
F 10
R 10
Q 0c
F 0f
R 11
R 12
R 13
R 14
R 15
R 16
R 17
W 20
R 18
W 21
R 19
W 22
R 1a
W 23
R 1b
W 24
R 1c
W 25
R 1d
W 26
R 1e
W 27
R 1f
Q 0c
F 08
W 28
W 29
W 2a
W 2b
W 2c
W 2d
W 2e
W 2f
Q 0c
F 10
R 20
R 21
R 22
R 23
R 24
R 25
R 26
R 27
R 28
R 29
R 2a
R 2b
R 2c
R 2d
R 2e
Q 0c
F 01
R 2f
R 2f
Q 0c
F 00

// ==== all.f ====
design/fifo_pkg.sv
design/dual_port_ram.sv
design/gray_ptr_sync.sv
design/wr_ptr_ctrl.sv
design/rd_ptr_ctrl.sv
design/async_fifo.sv
dv/async_fifo_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator; the exit status follows the pass line in the output.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f all.f --top-module async_fifo_tb &&
  ./obj_dir/Vasync_fifo_tb 2>&1 | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
  echo "run.sh: simulation ok" ||
  { echo "run.sh: simulation not ok"; exit 1; }

// ==== dv/async_fifo_tb.sv ====
`timescale 1ns/1ps

module async_fifo_tb;

  import fifo_pkg::*;

  localparam int    DATA_WIDTH  = DEF_DATA_WIDTH;
  localparam int    FIFO_DEPTH  = DEF_FIFO_DEPTH;
  localparam int    FIFO_AFULL  = DEF_FIFO_AFULL;
  localparam int    FIFO_AEMPTY = DEF_FIFO_AEMPTY;
  localparam int    RD_PERIOD   = 4;
  localparam int    WR_PERIOD   = 6;                   // differs from rd_clk so the domains drift.
  localparam string STIM_FILE   = "dv/fifo_stimulus.txt";

  typedef enum logic [7:0] {
    OP_WRITE = 8'h57,                                  // ascii W.
    OP_READ  = 8'h52,                                  // ascii R.
    OP_FLAGS = 8'h46,                                  // ascii F.
    OP_QUIET = 8'h51                                   // ascii Q.
  } stim_op_e;

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b0;
  logic                  wr_rst_n;
  logic                  rd_rst_n;
  logic                  wr_en;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  full;
  logic                  empty;
  logic                  afull;
  logic                  aempty;

  logic [DATA_WIDTH-1:0] model_q[$];                   // words the FIFO holds, oldest first.
  logic [DATA_WIDTH-1:0] last_rd;
  stim_op_e              op_list[$];
  logic [DATA_WIDTH-1:0] arg_list[$];
  bit                    loaded;

  always #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

  async_fifo dut_i (
    .wr_clk, .wr_rst_n, .wr_en, .wr_data,
    .rd_clk, .rd_rst_n, .rd_en, .rd_data,
    .full, .empty, .afull, .aempty
  );

  //////////////////////////////////////////////////
  // failure handling and compares
  //////////////////////////////////////////////////
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                            input logic [DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus file and operations
  //////////////////////////////////////////////////
  task automatic load_stimulus();
    int                    fd;
    int                    n;
    string                 line;
    logic [7:0]            op_c;
    logic [DATA_WIDTH-1:0] arg;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      stop_run({"cannot open the stimulus file ", STIM_FILE});
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin          // lines starting with # are notes.
        if ($sscanf(line, "%c %h", op_c, arg) != 2) begin
          stop_run({"a stimulus line cannot be parsed: ", line});
        end
        op_list.push_back(stim_op_e'(op_c));
        arg_list.push_back(arg);
      end
    end
    $fclose(fd);
  endtask

  task automatic write_word(input logic [DATA_WIDTH-1:0] data);
    logic blocked;
    @(negedge wr_clk);
    blocked = full;                                    // the value the next rising edge sees.
    wr_en   = 1'b1;
    wr_data = data;
    @(negedge wr_clk);
    wr_en = 1'b0;
    if (!blocked) begin
      model_q.push_back(data);
    end
    // the write side can only overcount, so these hold whatever the crossing lag.
    if (model_q.size() == FIFO_DEPTH) begin
      check_flag("full", 1'b1, full);
    end
    if (model_q.size() >= FIFO_AFULL) begin
      check_flag("afull", 1'b1, afull);
    end
  endtask

  task automatic read_word(input logic [DATA_WIDTH-1:0] file_exp);
    logic blocked;
    @(negedge rd_clk);
    blocked = empty;
    rd_en   = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
    if (!blocked) begin
      if (model_q.size() == 0) begin
        stop_run("the DUT accepted a read although nothing was stored");
      end
      last_rd = model_q.pop_front();
    end
    if (file_exp !== last_rd) begin
      stop_run($sformatf("stimulus file expects %h but the queue gives %h", file_exp, last_rd));
    end
    check_data("rd_data", last_rd, rd_data);           // a refused read keeps the old word.
    if (model_q.size() == 0) begin
      check_flag("empty", 1'b1, empty);
    end
    if (model_q.size() <= FIFO_AEMPTY) begin
      check_flag("aempty", 1'b1, aempty);
    end
  endtask

  task automatic expect_settled_flags(input int count);
    int fill;
    fill = model_q.size();
    if (fill != count) begin
      stop_run($sformatf("stimulus file expects %0d entries but the queue holds %0d",
                         count, fill));
    end
    @(negedge wr_clk);
    check_flag("full", fill == FIFO_DEPTH, full);
    check_flag("afull", fill >= FIFO_AFULL, afull);
    @(negedge rd_clk);
    check_flag("empty", fill == 0, empty);
    check_flag("aempty", fill <= FIFO_AEMPTY, aempty);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    last_rd  = '0;                                     // rd_data clears on reset.
    void'($urandom(32'h6a32));
    load_stimulus();
    loaded = 1'b1;
    repeat (5) @(posedge rd_clk);
    @(negedge rd_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    check_flag("full", 1'b0, full);
    check_flag("afull", 1'b0, afull);
    foreach (op_list[i]) begin
      repeat ($urandom % 4) @(negedge rd_clk);         // idle gap of 0 to 3 cycles.
      case (op_list[i])
        OP_WRITE: write_word(arg_list[i]);
        OP_READ:  read_word(arg_list[i]);
        OP_FLAGS: expect_settled_flags(int'(arg_list[i]));
        OP_QUIET: repeat (int'(arg_list[i])) @(negedge rd_clk);
        default:  stop_run($sformatf("stimulus line %0d has an unknown operation", i));
      endcase
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    wait (loaded);
    #(op_list.size() * 20 * RD_PERIOD + 200);
    $display("timeout: the stimulus did not complete within the time limit");
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== design/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_WIDTH  = fifo_pkg::DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = fifo_pkg::DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL  = fifo_pkg::DEF_FIFO_AFULL,
  parameter int FIFO_AEMPTY = fifo_pkg::DEF_FIFO_AEMPTY
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  empty,
  output logic                  afull,
  output logic                  aempty
);

  import fifo_pkg::*;

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int PTR_WIDTH  = ADDR_WIDTH + 1;        // one extra bit tells full from empty.

  logic                  ram_we;
  logic                  ram_re;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [PTR_WIDTH-1:0]  wr_gray;
  logic [PTR_WIDTH-1:0]  rd_gray;
  logic [PTR_WIDTH-1:0]  wr_ptr_rsync;
  logic [PTR_WIDTH-1:0]  rd_ptr_wsync;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////
  dual_port_ram #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) ram_i (
    .wr_clk, .wr_en(ram_we), .wr_addr, .wr_data,
    .rd_clk, .rd_rst_n, .rd_en(ram_re), .rd_addr, .rd_data
  );

  //////////////////////////////////////////////////
  // pointer control, one per domain
  //////////////////////////////////////////////////
  wr_ptr_ctrl #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_AFULL(FIFO_AFULL)) wr_ctrl_i (
    .wr_clk, .wr_rst_n, .wr_en, .rd_ptr_wsync,
    .ram_we, .wr_addr, .wr_gray, .full, .afull
  );

  rd_ptr_ctrl #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_AEMPTY(FIFO_AEMPTY)) rd_ctrl_i (
    .rd_clk, .rd_rst_n, .rd_en, .wr_ptr_rsync,
    .ram_re, .rd_addr, .rd_gray, .empty, .aempty
  );

  //////////////////////////////////////////////////
  // pointer crossings
  //////////////////////////////////////////////////
  gray_ptr_sync #(.PTR_WIDTH(PTR_WIDTH)) wr2rd_sync_i (
    .clk(rd_clk), .rst_n(rd_rst_n),
    .gray_in(wr_gray), .bin_out(wr_ptr_rsync)
  );

  gray_ptr_sync #(.PTR_WIDTH(PTR_WIDTH)) rd2wr_sync_i (
    .clk(wr_clk), .rst_n(wr_rst_n),
    .gray_in(rd_gray), .bin_out(rd_ptr_wsync)
  );

endmodule

// ==== design/rd_ptr_ctrl.sv ====
`timescale 1ns/1ps

module rd_ptr_ctrl #(
  parameter  int FIFO_DEPTH  = fifo_pkg::DEF_FIFO_DEPTH,
  parameter  int FIFO_AEMPTY = fifo_pkg::DEF_FIFO_AEMPTY,
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH),
  localparam int PTR_WIDTH   = ADDR_WIDTH + 1
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [PTR_WIDTH-1:0]  wr_ptr_rsync,
  output logic                  ram_re,
  output logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [PTR_WIDTH-1:0]  rd_gray,
  output logic                  empty,
  output logic                  aempty
);

  import fifo_pkg::*;

  logic [PTR_WIDTH-1:0]     rd_ptr;
  logic [PTR_WIDTH-1:0]     rd_ptr_nxt;
  logic [PTR_WIDTH-1:0]     used_cnt;
  logic [PTR_WIDTH-1:0]     used_nxt;
  logic [PTR_MAX_WIDTH-1:0] gray_nxt_wide;
  logic                     empty_nxt;
  logic                     aempty_nxt;

  //////////////////////////////////////////////////
  // read qualification and next pointer
  //////////////////////////////////////////////////
  assign ram_re        = rd_en & ~empty;               // a strobe against empty is dropped.
  assign rd_ptr_nxt    = rd_ptr + PTR_WIDTH'(ram_re);
  assign rd_addr       = rd_ptr[ADDR_WIDTH-1:0];
  assign gray_nxt_wide = bin_to_gray(PTR_MAX_WIDTH'(rd_ptr_nxt));

  // the synchronized write pointer may lag, so the count errs toward empty.
  assign used_cnt   = wr_ptr_rsync - rd_ptr;
  assign used_nxt   = wr_ptr_rsync - rd_ptr_nxt;

  assign empty_nxt  = rd_ptr_nxt == wr_ptr_rsync;
  assign aempty_nxt = used_nxt <= PTR_WIDTH'(FIFO_AEMPTY);

  //////////////////////////////////////////////////
  // pointer, gray copy and flag registers
  //////////////////////////////////////////////////
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;                               // nothing stored out of reset.
      aempty  <= 1'b1;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= gray_nxt_wide[PTR_WIDTH-1:0];
      empty   <= empty_nxt;
      aempty  <= aempty_nxt;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  // a read may only take an entry the writer has published across the crossing.
  a_no_read_when_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    ram_re |-> (used_cnt != '0)
  ) else $error("read accepted with no stored entry");

  // the mirror of the write side bound, seen from the read domain.
  a_rd_used_in_range : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    used_cnt <= PTR_WIDTH'(FIFO_DEPTH)
  ) else $error("read side used count exceeds the depth");

endmodule

// ==== design/wr_ptr_ctrl.sv ====
`timescale 1ns/1ps

module wr_ptr_ctrl #(
  parameter  int FIFO_DEPTH = fifo_pkg::DEF_FIFO_DEPTH,
  parameter  int FIFO_AFULL = fifo_pkg::DEF_FIFO_AFULL,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH),
  localparam int PTR_WIDTH  = ADDR_WIDTH + 1
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [PTR_WIDTH-1:0]  rd_ptr_wsync,
  output logic                  ram_we,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output logic [PTR_WIDTH-1:0]  wr_gray,
  output logic                  full,
  output logic                  afull
);

  import fifo_pkg::*;

  logic [PTR_WIDTH-1:0]     wr_ptr;
  logic [PTR_WIDTH-1:0]     wr_ptr_nxt;
  logic [PTR_WIDTH-1:0]     used_cnt;
  logic [PTR_WIDTH-1:0]     used_nxt;
  logic [PTR_MAX_WIDTH-1:0] gray_nxt_wide;
  logic                     full_nxt;
  logic                     afull_nxt;

  //////////////////////////////////////////////////
  // write qualification and next pointer
  //////////////////////////////////////////////////
  assign ram_we        = wr_en & ~full;                // a strobe against full is dropped.
  assign wr_ptr_nxt    = wr_ptr + PTR_WIDTH'(ram_we);
  assign wr_addr       = wr_ptr[ADDR_WIDTH-1:0];
  assign gray_nxt_wide = bin_to_gray(PTR_MAX_WIDTH'(wr_ptr_nxt));

  // used counts against the synchronized read pointer, which may lag.
  assign used_cnt  = wr_ptr - rd_ptr_wsync;
  assign used_nxt  = wr_ptr_nxt - rd_ptr_wsync;

  // full when the addresses meet but the wrap bits differ.
  assign full_nxt  = (wr_ptr_nxt[ADDR_WIDTH] != rd_ptr_wsync[ADDR_WIDTH]) &&
                     (wr_ptr_nxt[ADDR_WIDTH-1:0] == rd_ptr_wsync[ADDR_WIDTH-1:0]);
  assign afull_nxt = used_nxt >= PTR_WIDTH'(FIFO_AFULL);

  //////////////////////////////////////////////////
  // pointer, gray copy and flag registers
  //////////////////////////////////////////////////
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= gray_nxt_wide[PTR_WIDTH-1:0];       // registered so only one bit moves.
      full    <= full_nxt;
      afull   <= afull_nxt;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  // the registered full flag must already cover any entry the reader has not freed.
  a_no_write_when_full : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    ram_we |-> (used_cnt < PTR_WIDTH'(FIFO_DEPTH))
  ) else $error("write accepted with no free entry");

  a_used_in_range : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    used_cnt <= PTR_WIDTH'(FIFO_DEPTH)
  ) else $error("write side used count exceeds the depth");

endmodule

// ==== design/gray_ptr_sync.sv ====
`timescale 1ns/1ps

module gray_ptr_sync #(
  parameter int PTR_WIDTH = $clog2(fifo_pkg::DEF_FIFO_DEPTH) + 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [PTR_WIDTH-1:0] gray_in,
  output logic [PTR_WIDTH-1:0] bin_out
);

  import fifo_pkg::*;

  logic [PTR_WIDTH-1:0]     sync_q1;
  logic [PTR_WIDTH-1:0]     sync_q2;
  logic [PTR_MAX_WIDTH-1:0] out_bin_wide;

  // two flops; the first may go metastable, the second gives it a cycle to settle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  assign out_bin_wide = gray_to_bin(PTR_MAX_WIDTH'(sync_q2));
  assign bin_out      = out_bin_wide[PTR_WIDTH-1:0];   // binary for the flag arithmetic.

  // the registered gray source may move only one bit between two samples of this clock.
  a_gray_one_bit_step : assert property (
    @(posedge clk) disable iff (!rst_n)
    $countones(gray_in ^ $past(gray_in)) <= 1
  ) else $error("gray pointer changed more than one bit between samples");

endmodule

// ==== design/dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram #(
  parameter  int DATA_WIDTH = fifo_pkg::DEF_DATA_WIDTH,
  parameter  int FIFO_DEPTH = fifo_pkg::DEF_FIFO_DEPTH,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  import fifo_pkg::*;

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  //////////////////////////////////////////////////
  // write port, wr_clk domain
  //////////////////////////////////////////////////
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // registered read port, rd_clk domain
  //////////////////////////////////////////////////
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];                       // holds its value between reads.
    end
  end

endmodule

// ==== design/fifo_pkg.sv ====
package fifo_pkg;

  //////////////////////////////////////////////////
  // default geometry and thresholds
  //////////////////////////////////////////////////
  parameter int DEF_DATA_WIDTH  = 8;
  parameter int DEF_FIFO_DEPTH  = 16;                  // must stay a power of two.
  parameter int DEF_FIFO_AFULL  = DEF_FIFO_DEPTH - 1;
  parameter int DEF_FIFO_AEMPTY = 1;

  parameter int PTR_MAX_WIDTH   = 16;                  // callers use the low bits only.

  //////////////////////////////////////////////////
  // gray code conversion
  //////////////////////////////////////////////////
  function automatic logic [PTR_MAX_WIDTH-1:0] bin_to_gray(
    input logic [PTR_MAX_WIDTH-1:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [PTR_MAX_WIDTH-1:0] gray_to_bin(
    input logic [PTR_MAX_WIDTH-1:0] gray
  );
    logic [PTR_MAX_WIDTH-1:0] bin;
    bin[PTR_MAX_WIDTH-1] = gray[PTR_MAX_WIDTH-1];
    for (int i = PTR_MAX_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];                     // each bit folds in everything above it.
    end
    return bin;
  endfunction

endpackage
